//--- fcpu_pkg.sv
package fcpu_pkg;

   localparam int DATA_W     = 32;
   localparam int ROB_ID_W   = 5;
   localparam int N_OPERANDS = 2;
   localparam int OP_W       = 3;
   localparam int SHAMT_W    = $clog2(DATA_W);

   typedef enum logic [OP_W-1:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_XOR = 3'd4,
      ALU_SLL = 3'd5,
      ALU_SRL = 3'd6,
      ALU_SLT = 3'd7
   } alu_op_e;

   typedef struct packed {
      logic                valid;
      logic [ROB_ID_W-1:0] tag;
      logic [DATA_W-1:0]   data;
   } cdb_t;

   function automatic logic [DATA_W-1:0] alu_compute(alu_op_e op,
                                                     logic [DATA_W-1:0] a,
                                                     logic [DATA_W-1:0] b);
      logic [DATA_W-1:0] r;
      case (op)
         ALU_ADD: r = a + b;
         ALU_SUB: r = a - b;
         ALU_AND: r = a & b;
         ALU_OR:  r = a | b;
         ALU_XOR: r = a ^ b;
         ALU_SLL: r = a << b[SHAMT_W-1:0];
         ALU_SRL: r = a >> b[SHAMT_W-1:0];
         // signed compare
         ALU_SLT: r = ($signed(a) < $signed(b)) ? DATA_W'(1) : '0;
         default: r = '0;
      endcase
      return r;
   endfunction

endpackage

//--- rsv_pkg.sv
package rsv_pkg;

   localparam int N_RS         = 4;
   localparam int RS_SEL_W     = (N_RS > 1) ? $clog2(N_RS) : 1;
   localparam int RS_ENTRIES_W = 2;

   typedef struct packed {
      logic                          filled;
      logic [fcpu_pkg::ROB_ID_W-1:0] tag;
      logic [fcpu_pkg::DATA_W-1:0]   data;
   } src_t;

   typedef struct packed {
      logic [fcpu_pkg::ROB_ID_W-1:0]    rob_id;
      fcpu_pkg::alu_op_e                op;
      logic                             ordered;
      src_t [fcpu_pkg::N_OPERANDS-1:0] src;
   } disp_t;

   typedef struct packed {
      logic [fcpu_pkg::ROB_ID_W-1:0]                          rob_id;
      fcpu_pkg::alu_op_e                                      op;
      logic [fcpu_pkg::N_OPERANDS-1:0][fcpu_pkg::DATA_W-1:0] data;
   } issue_t;

endpackage

//--- rsv_if.sv
`timescale 1ns/1ps

interface rsv_if;
   import rsv_pkg::*;

   // dispatch side
   logic   disp_valid;
   logic   disp_ready;
   disp_t  disp;

   // issue side
   logic   iss_valid;
   issue_t iss;
   logic   iss_grant;

   modport router (
      output disp_valid,
      output disp,
      input  disp_ready
   );

   modport station (
      input  disp_valid,
      input  disp,
      output disp_ready,
      output iss_valid,
      output iss,
      input  iss_grant
   );

   modport issuer (
      input  iss_valid,
      input  iss,
      output iss_grant
   );

endinterface

//--- dispatch_router.sv
`timescale 1ns/1ps

module dispatch_router (
   input  logic           clk,
   input  logic           nrst,
   input  logic           i_valid,
   input  rsv_pkg::disp_t i_disp,
   output logic           o_ready,
   rsv_if.router          rs [rsv_pkg::N_RS]
);
   import rsv_pkg::*;

   logic [N_RS-1:0]     ready_v;
   logic [N_RS-1:0]     sel_v;
   logic [RS_SEL_W-1:0] ptr_q;
   logic [RS_SEL_W-1:0] target;
   logic                hit;
   logic                accept;

   for (genvar g = 0; g < N_RS; g++) begin : g_port
      assign ready_v[g]       = rs[g].disp_ready;
      assign rs[g].disp_valid = sel_v[g];
      assign rs[g].disp       = i_disp;
   end

   always_comb begin
      int idx;
      idx    = 0;
      target = '0;
      hit    = 1'b0;
      if (i_disp.ordered) begin
         // ordered stream lives in station 0 only
         hit = ready_v[0];
      end else begin
         for (int k = 0; k < N_RS; k++) begin
            idx = (int'(ptr_q) + k) % N_RS;
            if (!hit && ready_v[idx]) begin
               hit    = 1'b1;
               target = RS_SEL_W'(idx);
            end
         end
      end
   end

   assign o_ready = hit;
   assign accept  = i_valid && hit;

   always_comb begin
      sel_v         = '0;
      sel_v[target] = accept;
   end

   // rotate past the station just used
   always_ff @(posedge clk) begin
      if (nrst) begin
         ptr_q <= '0;
      end else if (accept && !i_disp.ordered) begin
         ptr_q <= (target == RS_SEL_W'(N_RS - 1)) ? '0 : target + 1'b1;
      end
   end

   // back-to-back unordered dispatches spread to another free station
   for (genvar g = 0; g < N_RS; g++) begin : g_spread
      a_spread: assert property (@(posedge clk) disable iff (nrst)
         $past(!nrst && accept && !i_disp.ordered && sel_v[g])
            && !i_disp.ordered && ((ready_v & ~(N_RS'(1) << g)) != '0)
            |-> !sel_v[g]);
   end

endmodule

//--- reservation_station.sv
`timescale 1ns/1ps

module reservation_station #(
   parameter int RS_ENTRIES_W = rsv_pkg::RS_ENTRIES_W
) (
   input  logic           clk,
   input  logic           nrst,
   rsv_if.station         rs,
   input  fcpu_pkg::cdb_t i_cdb
);
   import fcpu_pkg::*;
   import rsv_pkg::*;

   typedef struct packed {
      logic                    ordered;
      logic [RS_ENTRIES_W-1:0] seq;
      logic [ROB_ID_W-1:0]     rob_id;
      alu_op_e                 op;
      src_t [N_OPERANDS-1:0]   src;
   } entry_t;

   logic [2**RS_ENTRIES_W-1:0] valid_q;
   entry_t                     entries_q [2**RS_ENTRIES_W];
   entry_t                     new_entry;
   logic [RS_ENTRIES_W-1:0]    seq_q;
   logic [RS_ENTRIES_W-1:0]    rel_q;
   logic [2**RS_ENTRIES_W-1:0] elig_v;
   logic [RS_ENTRIES_W-1:0]    free_idx;
   logic [RS_ENTRIES_W-1:0]    iss_idx;
   logic                       wr_en;
   logic                       rd_en;

   function automatic logic wakes(src_t s, cdb_t c);
      return c.valid && !s.filled && (s.tag == c.tag);
   endfunction

   assign rs.disp_ready = ~&valid_q;
   assign wr_en         = rs.disp_valid && rs.disp_ready;
   assign rd_en         = rs.iss_valid && rs.iss_grant;

   // ordered entries wait for their turn
   always_comb begin
      for (int i = 0; i < 2**RS_ENTRIES_W; i++) begin
         elig_v[i] = valid_q[i] && (!entries_q[i].ordered || entries_q[i].seq == rel_q);
         for (int j = 0; j < N_OPERANDS; j++) begin
            elig_v[i] = elig_v[i] && entries_q[i].src[j].filled;
         end
      end
   end

   // scan downwards so the lowest index wins
   always_comb begin
      free_idx = '0;
      iss_idx  = '0;
      for (int i = 2**RS_ENTRIES_W - 1; i >= 0; i--) begin
         if (!valid_q[i]) begin
            free_idx = RS_ENTRIES_W'(i);
         end
         if (elig_v[i]) begin
            iss_idx = RS_ENTRIES_W'(i);
         end
      end
   end

   assign rs.iss_valid = |elig_v;

   always_comb begin
      rs.iss.rob_id = entries_q[iss_idx].rob_id;
      rs.iss.op     = entries_q[iss_idx].op;
      for (int j = 0; j < N_OPERANDS; j++) begin
         rs.iss.data[j] = entries_q[iss_idx].src[j].data;
      end
   end

   always_comb begin
      new_entry.ordered = rs.disp.ordered;
      new_entry.seq     = seq_q;
      new_entry.rob_id  = rs.disp.rob_id;
      new_entry.op      = rs.disp.op;
      for (int j = 0; j < N_OPERANDS; j++) begin
         new_entry.src[j] = rs.disp.src[j];
         // producer broadcasting in the dispatch cycle
         if (wakes(rs.disp.src[j], i_cdb)) begin
            new_entry.src[j].filled = 1'b1;
            new_entry.src[j].data   = i_cdb.data;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         valid_q <= '0;
         seq_q   <= '0;
         rel_q   <= '0;
      end else begin
         if (wr_en) begin
            valid_q[free_idx] <= 1'b1;
            if (rs.disp.ordered) begin
               seq_q <= seq_q + 1'b1;
            end
         end
         if (rd_en) begin
            valid_q[iss_idx] <= 1'b0;
            if (entries_q[iss_idx].ordered) begin
               rel_q <= rel_q + 1'b1;
            end
         end
      end
   end

   // cdb snoop on held entries
   always_ff @(posedge clk) begin
      for (int i = 0; i < 2**RS_ENTRIES_W; i++) begin
         for (int j = 0; j < N_OPERANDS; j++) begin
            if (valid_q[i] && wakes(entries_q[i].src[j], i_cdb)) begin
               entries_q[i].src[j].filled <= 1'b1;
               entries_q[i].src[j].data   <= i_cdb.data;
            end
         end
      end
      if (wr_en) begin
         entries_q[free_idx] <= new_entry;
      end
   end

   a_no_write_full: assert property (@(posedge clk) disable iff (nrst)
      rs.disp_valid |-> rs.disp_ready);

   a_grant_valid: assert property (@(posedge clk) disable iff (nrst)
      rs.iss_grant |-> rs.iss_valid);

endmodule

//--- alu_issue.sv
`timescale 1ns/1ps

module alu_issue (
   input  logic           clk,
   input  logic           nrst,
   input  logic           i_stall,
   rsv_if.issuer          rs [rsv_pkg::N_RS],
   output fcpu_pkg::cdb_t o_cdb
);
   import fcpu_pkg::*;
   import rsv_pkg::*;

   logic [N_RS-1:0]     req_v;
   logic [N_RS-1:0]     grant_v;
   issue_t              iss_v [N_RS];
   issue_t              win_iss;
   logic [RS_SEL_W-1:0] ptr_q;
   logic [RS_SEL_W-1:0] win;
   logic                found;
   logic                cdb_valid_q;
   logic [ROB_ID_W-1:0] cdb_tag_q;
   logic [DATA_W-1:0]   cdb_data_q;

   for (genvar g = 0; g < N_RS; g++) begin : g_port
      assign req_v[g]        = rs[g].iss_valid;
      assign iss_v[g]        = rs[g].iss;
      assign rs[g].iss_grant = grant_v[g];
   end

   // first requester at or after the pointer
   always_comb begin
      int idx;
      idx   = 0;
      win   = '0;
      found = 1'b0;
      for (int k = 0; k < N_RS; k++) begin
         idx = (int'(ptr_q) + k) % N_RS;
         if (!found && req_v[idx]) begin
            found = 1'b1;
            win   = RS_SEL_W'(idx);
         end
      end
   end

   always_comb begin
      grant_v      = '0;
      grant_v[win] = found && !i_stall;
   end

   assign win_iss = iss_v[win];

   always_ff @(posedge clk) begin
      if (nrst) begin
         ptr_q       <= '0;
         cdb_valid_q <= 1'b0;
      end else begin
         cdb_valid_q <= |grant_v;
         if (|grant_v) begin
            ptr_q <= (win == RS_SEL_W'(N_RS - 1)) ? '0 : win + 1'b1;
         end
      end
   end

   // single-cycle alu into the cdb register
   always_ff @(posedge clk) begin
      if (|grant_v) begin
         cdb_tag_q  <= win_iss.rob_id;
         cdb_data_q <= alu_compute(win_iss.op, win_iss.data[0], win_iss.data[1]);
      end
   end

   assign o_cdb.valid = cdb_valid_q;
   assign o_cdb.tag   = cdb_tag_q;
   assign o_cdb.data  = cdb_data_q;

   // a station just served yields to any other requester
   for (genvar g = 0; g < N_RS; g++) begin : g_fair
      a_rr_fair: assert property (@(posedge clk) disable iff (nrst)
         $past(!nrst && grant_v[g]) && ((req_v & ~(N_RS'(1) << g)) != '0)
            |-> !grant_v[g]);
   end

endmodule

//--- ooo_cluster_top.sv
`timescale 1ns/1ps

module ooo_cluster_top (
   input  logic                          clk,
   input  logic                          nrst,
   input  logic                          i_valid,
   input  logic [fcpu_pkg::ROB_ID_W-1:0] i_rob_id,
   input  logic [fcpu_pkg::OP_W-1:0]     i_op,
   input  logic                          i_ordered,
   input  logic                          i_src0_filled,
   input  logic [fcpu_pkg::ROB_ID_W-1:0] i_src0_tag,
   input  logic [fcpu_pkg::DATA_W-1:0]   i_src0_data,
   input  logic                          i_src1_filled,
   input  logic [fcpu_pkg::ROB_ID_W-1:0] i_src1_tag,
   input  logic [fcpu_pkg::DATA_W-1:0]   i_src1_data,
   input  logic                          i_stall,
   output logic                          o_ready,
   output logic                          o_cdb_valid,
   output logic [fcpu_pkg::ROB_ID_W-1:0] o_cdb_tag,
   output logic [fcpu_pkg::DATA_W-1:0]   o_cdb_data
);
   import fcpu_pkg::*;
   import rsv_pkg::*;

   disp_t disp;
   cdb_t  cdb;

   rsv_if rs_bus [N_RS] ();

   always_comb begin
      disp.rob_id  = i_rob_id;
      disp.op      = alu_op_e'(i_op);
      disp.ordered = i_ordered;
      disp.src[0]  = '{filled: i_src0_filled, tag: i_src0_tag, data: i_src0_data};
      disp.src[1]  = '{filled: i_src1_filled, tag: i_src1_tag, data: i_src1_data};
   end

   dispatch_router i_router (
      .clk     (clk),
      .nrst    (nrst),
      .i_valid (i_valid),
      .i_disp  (disp),
      .o_ready (o_ready),
      .rs      (rs_bus)
   );

   for (genvar g = 0; g < N_RS; g++) begin : g_rs
      reservation_station #(
         .RS_ENTRIES_W (RS_ENTRIES_W)
      ) i_rs (
         .clk   (clk),
         .nrst  (nrst),
         .rs    (rs_bus[g]),
         .i_cdb (cdb)
      );
   end

   alu_issue i_issue (
      .clk     (clk),
      .nrst    (nrst),
      .i_stall (i_stall),
      .rs      (rs_bus),
      .o_cdb   (cdb)
   );

   assign o_cdb_valid = cdb.valid;
   assign o_cdb_tag   = cdb.tag;
   assign o_cdb_data  = cdb.data;

endmodule

//--- tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
   input  logic                          clk,
   input  logic                          nrst,
   input  logic                          i_valid,
   input  logic                          i_ready,
   input  logic [fcpu_pkg::ROB_ID_W-1:0] i_rob_id,
   input  logic [fcpu_pkg::OP_W-1:0]     i_op,
   input  logic                          i_ordered,
   input  logic                          i_src0_filled,
   input  logic [fcpu_pkg::ROB_ID_W-1:0] i_src0_tag,
   input  logic [fcpu_pkg::DATA_W-1:0]   i_src0_data,
   input  logic                          i_src1_filled,
   input  logic [fcpu_pkg::ROB_ID_W-1:0] i_src1_tag,
   input  logic [fcpu_pkg::DATA_W-1:0]   i_src1_data,
   input  logic                          i_stall,
   input  logic                          i_cdb_valid,
   input  logic [fcpu_pkg::ROB_ID_W-1:0] i_cdb_tag,
   input  logic [fcpu_pkg::DATA_W-1:0]   i_cdb_data,
   output int                            o_errors,
   output int                            o_results,
   output int                            o_pending
);
   import fcpu_pkg::*;

   localparam int N_TAGS = 2**ROB_ID_W;

   logic [DATA_W-1:0]   exp_data [N_TAGS];
   logic [N_TAGS-1:0]   pending;
   logic [N_TAGS-1:0]   is_ordered;
   logic [ROB_ID_W-1:0] ord_q [$];
   logic                prev_stall;
   logic [DATA_W-1:0]   opa;
   logic [DATA_W-1:0]   opb;
   int                  errors = 0;
   int                  results = 0;

   function automatic logic [DATA_W-1:0] ref_result(alu_op_e op,
                                                    logic [DATA_W-1:0] a,
                                                    logic [DATA_W-1:0] b);
      logic [DATA_W-1:0] r;
      logic              lt;
      // differing signs decide the compare on their own
      lt = (a[DATA_W-1] != b[DATA_W-1]) ? a[DATA_W-1] : (a < b);
      case (op)
         ALU_ADD: r = a + b;
         ALU_SUB: r = a + ~b + 32'd1;
         ALU_AND: r = a & b;
         ALU_OR:  r = a | b;
         ALU_XOR: r = a ^ b;
         ALU_SLL: r = a << b[4:0];
         ALU_SRL: r = a >> b[4:0];
         ALU_SLT: r = {{(DATA_W-1){1'b0}}, lt};
         default: r = '0;
      endcase
      return r;
   endfunction

   task automatic drop_ordered(input logic [ROB_ID_W-1:0] tag);
      for (int k = 0; k < ord_q.size(); k++) begin
         if (ord_q[k] == tag) begin
            ord_q.delete(k);
            break;
         end
      end
   endtask

   // mid-cycle sampling, all DUT ports settled
   always @(negedge clk) begin
      if (nrst) begin
         pending    = '0;
         is_ordered = '0;
         ord_q.delete();
         for (int t = 0; t < N_TAGS; t++) begin
            exp_data[t] = '0;
         end
      end else begin
         if (i_cdb_valid) begin
            if (prev_stall) begin
               errors++;
               $display("cdb result for tag %h appeared while issue was stalled", i_cdb_tag);
            end
            if (!pending[i_cdb_tag]) begin
               errors++;
               $display("cdb result for tag %h with no instruction in flight", i_cdb_tag);
            end else begin
               results++;
               pending[i_cdb_tag] = 1'b0;
               if (i_cdb_data !== exp_data[i_cdb_tag]) begin
                  errors++;
                  $display("mismatch o_cdb_data (tag %h): got %h, expected %h",
                           i_cdb_tag, i_cdb_data, exp_data[i_cdb_tag]);
               end
               // oldest outstanding ordered tag must come first
               if (is_ordered[i_cdb_tag]) begin
                  if (ord_q.size() > 0 && ord_q[0] != i_cdb_tag) begin
                     errors++;
                     $display("mismatch o_cdb_tag: got %h, expected %h", i_cdb_tag, ord_q[0]);
                  end
                  drop_ordered(i_cdb_tag);
               end
            end
         end
         if (i_valid && i_ready) begin
            if (pending[i_rob_id]) begin
               errors++;
               $display("tag %h dispatched again while still in flight", i_rob_id);
            end
            opa = i_src0_filled ? i_src0_data : exp_data[i_src0_tag];
            opb = i_src1_filled ? i_src1_data : exp_data[i_src1_tag];
            exp_data[i_rob_id]   = ref_result(alu_op_e'(i_op), opa, opb);
            pending[i_rob_id]    = 1'b1;
            is_ordered[i_rob_id] = i_ordered;
            if (i_ordered) begin
               ord_q.push_back(i_rob_id);
            end
         end
      end
      prev_stall = i_stall;
   end

   assign o_errors  = errors;
   assign o_results = results;
   assign o_pending = $countones(pending);

endmodule

//--- tb_top.sv
`timescale 1ns/1ps

module tb_top;
   import fcpu_pkg::*;

   localparam int N_INDEP     = 16;
   localparam int N_CHAIN     = 26;
   localparam int N_ORDERED   = 24;
   localparam int N_STALL     = 24;
   localparam int N_RESET     = 26;
   localparam int N_SLOTS     = rsv_pkg::N_RS * (2**rsv_pkg::RS_ENTRIES_W);
   localparam int N_TOTAL     = N_INDEP + N_CHAIN + N_ORDERED + N_STALL + N_RESET;
   localparam int CYCLE_LIMIT = 40 * N_TOTAL + 100;

   logic                clk;
   logic                nrst;
   logic                i_valid;
   logic [ROB_ID_W-1:0] i_rob_id;
   logic [OP_W-1:0]     i_op;
   logic                i_ordered;
   logic                i_src0_filled;
   logic [ROB_ID_W-1:0] i_src0_tag;
   logic [DATA_W-1:0]   i_src0_data;
   logic                i_src1_filled;
   logic [ROB_ID_W-1:0] i_src1_tag;
   logic [DATA_W-1:0]   i_src1_data;
   logic                i_stall;
   logic                o_ready;
   logic                o_cdb_valid;
   logic [ROB_ID_W-1:0] o_cdb_tag;
   logic [DATA_W-1:0]   o_cdb_data;
   int                  chk_errors;
   int                  chk_results;
   int                  chk_pending;

   logic [31:0]           seed;
   logic [2**ROB_ID_W-1:0] busy;
   logic [ROB_ID_W-1:0]   ring [8];
   int                    ring_n;
   int                    ring_wr;
   int                    tag_ptr;
   logic [ROB_ID_W-1:0]   last_tag;
   logic [ROB_ID_W-1:0]   dep_tag [2];
   logic                  dep_wait [2];
   logic [DATA_W-1:0]     src_data [2];
   logic                  stall_mode;
   int                    stall_left;
   logic                  saw_full;
   int                    tb_errors;
   int                    res_mark;
   int                    err_mark;
   int                    cycles = 0;

   ooo_cluster_top i_dut (
      .clk           (clk),
      .nrst          (nrst),
      .i_valid       (i_valid),
      .i_rob_id      (i_rob_id),
      .i_op          (i_op),
      .i_ordered     (i_ordered),
      .i_src0_filled (i_src0_filled),
      .i_src0_tag    (i_src0_tag),
      .i_src0_data   (i_src0_data),
      .i_src1_filled (i_src1_filled),
      .i_src1_tag    (i_src1_tag),
      .i_src1_data   (i_src1_data),
      .i_stall       (i_stall),
      .o_ready       (o_ready),
      .o_cdb_valid   (o_cdb_valid),
      .o_cdb_tag     (o_cdb_tag),
      .o_cdb_data    (o_cdb_data)
   );

   tb_checker i_chk (
      .clk           (clk),
      .nrst          (nrst),
      .i_valid       (i_valid),
      .i_ready       (o_ready),
      .i_rob_id      (i_rob_id),
      .i_op          (i_op),
      .i_ordered     (i_ordered),
      .i_src0_filled (i_src0_filled),
      .i_src0_tag    (i_src0_tag),
      .i_src0_data   (i_src0_data),
      .i_src1_filled (i_src1_filled),
      .i_src1_tag    (i_src1_tag),
      .i_src1_data   (i_src1_data),
      .i_stall       (i_stall),
      .i_cdb_valid   (o_cdb_valid),
      .i_cdb_tag     (o_cdb_tag),
      .i_cdb_data    (o_cdb_data),
      .o_errors      (chk_errors),
      .o_results     (chk_results),
      .o_pending     (chk_pending)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // tags in flight, freed once their result shows on the cdb
   always @(negedge clk) begin
      if (nrst) begin
         busy = '0;
      end else begin
         if (o_cdb_valid) begin
            busy[o_cdb_tag] = 1'b0;
         end
         if (i_valid && o_ready) begin
            busy[i_rob_id] = 1'b1;
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > CYCLE_LIMIT) begin
         $display("timeout after %0d cycles, %0d instructions never completed",
                  cycles, chk_pending);
         $display("** FAIL **");
         $finish;
      end
   end

   function automatic logic [31:0] next_rand();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return {seed[15:0], seed[31:16]};
   endfunction

   function automatic int error_total();
      return tb_errors + chk_errors;
   endfunction

   // waiting sources whose producer already broadcast are sent filled
   task automatic apply_sources();
      for (int j = 0; j < 2; j++) begin
         if (dep_wait[j] && !busy[dep_tag[j]]) begin
            dep_wait[j] = 1'b0;
            src_data[j] = i_chk.exp_data[dep_tag[j]];
         end
      end
      i_src0_filled = !dep_wait[0];
      i_src0_tag    = dep_tag[0];
      i_src0_data   = src_data[0];
      i_src1_filled = !dep_wait[1];
      i_src1_tag    = dep_tag[1];
      i_src1_data   = src_data[1];
   endtask

   task automatic step();
      @(posedge clk);
      #1;
      if (stall_mode) begin
         if (stall_left > 0) begin
            stall_left--;
         end else begin
            i_stall    = !i_stall;
            stall_left = 1 + int'(next_rand() % 10);
         end
      end
      if (i_valid) begin
         apply_sources();
      end
   endtask

   task automatic send(input int op, input logic ordered, input int dep_pct, input int dep_on);
      int   t;
      int   k;
      int   pick;
      logic took;
      t = tag_ptr;
      for (k = 0; k < 2**ROB_ID_W; k++) begin
         t = (tag_ptr + k) % (2**ROB_ID_W);
         if (!busy[t]) begin
            break;
         end
      end
      tag_ptr   = (t + 1) % (2**ROB_ID_W);
      i_rob_id  = ROB_ID_W'(t);
      i_op      = (op < 0) ? OP_W'(next_rand() % 8) : OP_W'(op);
      i_ordered = ordered;
      for (k = 0; k < 2; k++) begin
         src_data[k] = next_rand();
         dep_tag[k]  = '0;
         dep_wait[k] = 1'b0;
         if (ring_n > 0 && int'(next_rand() % 100) < dep_pct) begin
            pick        = int'(next_rand() % ring_n);
            dep_tag[k]  = ring[pick];
            dep_wait[k] = 1'b1;
         end
      end
      if (dep_on >= 0) begin
         dep_tag[0]  = ROB_ID_W'(dep_on);
         dep_wait[0] = 1'b1;
      end
      apply_sources();
      i_valid = 1'b1;
      took    = 1'b0;
      while (!took) begin
         @(negedge clk);
         took = o_ready;
         if (!took) begin
            saw_full = 1'b1;
         end
         step();
      end
      i_valid       = 1'b0;
      last_tag      = ROB_ID_W'(t);
      ring[ring_wr] = ROB_ID_W'(t);
      ring_wr       = (ring_wr + 1) % 8;
      if (ring_n < 8) begin
         ring_n++;
      end
   endtask

   task automatic drain();
      while (chk_pending != 0) begin
         step();
      end
   endtask

   task automatic finish_test(input string name);
      drain();
      $display("%s: %0d results, %0d errors", name, chk_results - res_mark,
               error_total() - err_mark);
      res_mark = chk_results;
      err_mark = error_total();
   endtask

   task automatic apply_reset();
      nrst = 1'b1;
      repeat (4) @(posedge clk);
      #1;
      nrst = 1'b0;
   endtask

   initial begin
      seed          = 32'he3aa;
      nrst          = 1'b1;
      i_valid       = 1'b0;
      i_rob_id      = '0;
      i_op          = '0;
      i_ordered     = 1'b0;
      i_src0_filled = 1'b0;
      i_src0_tag    = '0;
      i_src0_data   = '0;
      i_src1_filled = 1'b0;
      i_src1_tag    = '0;
      i_src1_data   = '0;
      i_stall       = 1'b0;
      stall_mode    = 1'b0;
      stall_left    = 0;
      saw_full      = 1'b0;
      ring_n        = 0;
      ring_wr       = 0;
      tag_ptr       = 0;
      last_tag      = '0;
      tb_errors     = 0;
      res_mark      = 0;
      err_mark      = 0;
      apply_reset();

      for (int n = 0; n < N_INDEP; n++) begin
         send(n % 8, 1'b0, 0, -1);
      end
      finish_test("test 1 independent ops");

      // one idle cycle puts the consumer on the producer's broadcast cycle
      send(0, 1'b0, 0, -1);
      step();
      send(-1, 1'b0, 0, int'(last_tag));
      for (int n = 0; n < N_CHAIN - 2; n++) begin
         send(-1, 1'b0, 60, -1);
      end
      finish_test("test 2 dependency chains");

      for (int n = 0; n < N_ORDERED; n++) begin
         send(-1, 1'(next_rand() >> 7), 40, -1);
      end
      finish_test("test 3 ordered release");

      saw_full   = 1'b0;
      i_stall    = 1'b1;
      stall_left = 40;
      stall_mode = 1'b1;
      for (int n = 0; n < N_STALL; n++) begin
         send(-1, 1'b0, 30, -1);
      end
      drain();
      stall_mode = 1'b0;
      i_stall    = 1'b0;
      if (!saw_full) begin
         tb_errors++;
         $display("o_ready never dropped although all stations should have filled");
      end
      finish_test("test 4 stall back-pressure");

      // every entry held, so o_ready is low going into reset
      i_stall = 1'b1;
      for (int n = 0; n < N_SLOTS; n++) begin
         send(-1, 1'b0, 0, -1);
      end
      step();
      apply_reset();
      i_stall = 1'b0;
      ring_n  = 0;
      ring_wr = 0;
      @(negedge clk);
      if (o_ready !== 1'b1) begin
         tb_errors++;
         $display("mismatch o_ready after reset: got %h, expected 1", o_ready);
      end
      // stale entries would reach the cdb by now
      step();
      @(negedge clk);
      if (o_cdb_valid !== 1'b0) begin
         tb_errors++;
         $display("mismatch o_cdb_valid after reset: got %h, expected 0", o_cdb_valid);
      end
      step();
      for (int n = 0; n < N_RESET - N_SLOTS; n++) begin
         send(-1, 1'(next_rand() >> 9), 40, -1);
      end
      finish_test("test 5 reset in mid-run");

      $display("%0d results checked, %0d errors", chk_results, error_total());
      if (error_total() == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

//--- all.f
fcpu_pkg.sv
rsv_pkg.sv
rsv_if.sv
dispatch_router.sv
reservation_station.sv
alu_issue.sv
ooo_cluster_top.sv
tb_checker.sv
tb_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only when the pass line shows up in the simulation output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '** PASS **'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
